// File: Makefile
SIM      := verilator
TOP      := tb_mem_subsystem
FILELIST := src.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the simulator exits non-zero on $fatal
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mem_patterns.hex
// write size addr wdata expected_rdata expected_misaligned
// size codes 0 byte 1 half 2 word 3 double
1 3 0000 0123456789abcdef 0000000000000000 0
1 3 0008 fedcba9876543210 0000000000000000 0
1 3 0010 1111111111111111 0000000000000000 0
1 3 0018 2222222222222222 0000000000000000 0
0 3 0000 0000000000000000 0123456789abcdef 0
0 3 0008 0000000000000000 fedcba9876543210 0
1 0 0010 00000000000000a0 0000000000000000 0
1 0 0011 00000000000000a1 0000000000000000 0
1 0 0012 00000000000000a2 0000000000000000 0
1 0 0013 00000000000000a3 0000000000000000 0
1 0 0014 00000000000000a4 0000000000000000 0
1 0 0015 00000000000000a5 0000000000000000 0
1 0 0016 00000000000000a6 0000000000000000 0
1 0 0017 ffffffffffffffa7 0000000000000000 0
0 3 0010 0000000000000000 a7a6a5a4a3a2a1a0 0
1 1 001a 000000000000b1b0 0000000000000000 0
1 1 001e deadbeef0000c1c0 0000000000000000 0
0 3 0018 0000000000000000 c1c02222b1b02222 0
1 2 000c 00000000d3d2d1d0 0000000000000000 0
1 2 0008 cafef00de0e1e2e3 0000000000000000 0
0 3 0008 0000000000000000 d3d2d1d0e0e1e2e3 0
0 0 0013 0000000000000000 00000000000000a3 0
0 0 0017 0000000000000000 00000000000000a7 0
0 1 0014 0000000000000000 000000000000a5a4 0
0 1 001e 0000000000000000 000000000000c1c0 0
0 2 000c 0000000000000000 00000000d3d2d1d0 0
0 2 0000 0000000000000000 0000000089abcdef 0
0 2 0004 0000000000000000 0000000001234567 0
0 1 0002 0000000000000000 00000000000089ab 0
0 0 0006 0000000000000000 0000000000000023 0
1 1 0011 ffffffffffffffff 0000000000000000 1
1 2 0012 ffffffffffffffff 0000000000000000 1
1 3 0014 ffffffffffffffff 0000000000000000 1
0 3 0014 0000000000000000 0000000000000000 1
0 1 0003 0000000000000000 0000000000000000 1
0 2 000a 0000000000000000 0000000000000000 1
0 3 0010 0000000000000000 a7a6a5a4a3a2a1a0 0
1 3 0020 3333333333333333 0000000000000000 0
1 0 0025 0000000000000077 0000000000000000 0
0 3 0020 0000000000000000 3333773333333333 0

// File: bench/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
  import mem_pkg::*, lsu_pkg::*;
();

  localparam int DEPTH_WORDS    = 256;
  localparam int ADDR_WIDTH     = 16;
  localparam int CLK_HALF       = 20;
  localparam int NUM_PATTERNS   = 40;
  localparam int PAT_FIELDS     = 6;
  localparam int TIMEOUT_CYCLES = NUM_PATTERNS * 20 + 200;
  localparam int MODEL_BYTES    = DEPTH_WORDS * WORD_BYTES;

  logic                  clk;
  logic                  arst_n;
  logic                  fetch_req_valid;
  logic                  fetch_req_ready;
  logic [ADDR_WIDTH-1:0] fetch_req_addr;
  logic                  fetch_resp_valid;
  word_t                 fetch_resp_data;
  logic                  data_req_valid;
  logic                  data_req_ready;
  logic                  data_req_write;
  access_size_t          data_req_size;
  logic [ADDR_WIDTH-1:0] data_req_addr;
  word_t                 data_req_wdata;
  logic                  data_resp_valid;
  word_t                 data_resp_rdata;
  logic                  data_resp_misaligned;

  // six fields per access as laid out in the pattern file
  logic [63:0] pat_mem [NUM_PATTERNS*PAT_FIELDS];

  // byte image of the ram
  logic [7:0]  model_mem   [MODEL_BYTES];
  // bytes that were ever written
  logic        model_known [MODEL_BYTES];

  logic [31:0] rng_state;
  int          cur_idx;
  logic        data_done;

  // accepted at the last negedge with the response due at the next one
  logic        data_pend;
  int          data_pend_idx;
  logic        fetch_pend;
  word_t       fetch_exp;
  word_t       fetch_known;

  logic        have_grant;
  port_id_t    last_grant_seen;
  int          fetch_resps;
  int          contended;

  mem_subsystem #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .ADDR_WIDTH  (ADDR_WIDTH)
  ) DUT (
    .clk                  (clk),
    .arst_n               (arst_n),
    .fetch_req_valid      (fetch_req_valid),
    .fetch_req_ready      (fetch_req_ready),
    .fetch_req_addr       (fetch_req_addr),
    .fetch_resp_valid     (fetch_resp_valid),
    .fetch_resp_data      (fetch_resp_data),
    .data_req_valid       (data_req_valid),
    .data_req_ready       (data_req_ready),
    .data_req_write       (data_req_write),
    .data_req_size        (data_req_size),
    .data_req_addr        (data_req_addr),
    .data_req_wdata       (data_req_wdata),
    .data_resp_valid      (data_resp_valid),
    .data_resp_rdata      (data_resp_rdata),
    .data_resp_misaligned (data_resp_misaligned)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic fail_value(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic fail_event(input string what);
    $display("ERROR: %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // lanes off .. off+n-1 take the low n bytes of the store data
  task automatic apply_store(input logic [ADDR_WIDTH-1:0] addr, input logic [1:0] size,
                             input word_t wdata);
    int off;
    int nbytes;
    int base;
    off    = int'(addr[2:0]);
    nbytes = 1 << size;
    base   = int'(addr) - off;
    if (off % nbytes == 0) begin
      for (int b = 0; b < nbytes; b++) begin
        model_mem[base + off + b]   = wdata[b*8 +: 8];
        model_known[base + off + b] = 1'b1;
      end
    end
  endtask

  task automatic predict_fetch(input logic [ADDR_WIDTH-1:0] addr);
    int base;
    base = int'(addr) - int'(addr[2:0]);
    for (int b = 0; b < WORD_BYTES; b++) begin
      fetch_exp[b*8 +: 8]   = model_mem[base + b];
      fetch_known[b*8 +: 8] = model_known[base + b] ? 8'hff : 8'h00;
    end
  endtask

  task automatic check_responses();
    string tag;
    int    p;
    p = data_pend_idx * PAT_FIELDS;
    if (data_pend) begin
      tag = $sformatf("pattern %0d", data_pend_idx);
      assert (data_resp_valid)
        else fail_event({tag, " got no response one cycle after acceptance"});
      assert (data_resp_rdata === pat_mem[p+4])
        else fail_value({tag, " rdata"}, pat_mem[p+4], data_resp_rdata);
      assert (data_resp_misaligned === pat_mem[p+5][0])
        else fail_value({tag, " misaligned"}, 64'(pat_mem[p+5][0]), 64'(data_resp_misaligned));
    end else begin
      assert (!data_resp_valid) else fail_event("load/store response without a request");
    end
    if (fetch_pend) begin
      tag = $sformatf("fetch %0d data", fetch_resps);
      assert (fetch_resp_valid)
        else fail_event("fetch got no response one cycle after acceptance");
      // bytes never written hold no defined value
      assert ((fetch_resp_data & fetch_known) === (fetch_exp & fetch_known))
        else fail_value(tag, fetch_exp & fetch_known, fetch_resp_data & fetch_known);
      fetch_resps++;
    end else begin
      assert (!fetch_resp_valid) else fail_event("fetch response without a request");
    end
  endtask

  task automatic check_grant();
    logic fetch_should_win;
    if (fetch_req_valid && data_req_valid) begin
      contended++;
      assert (fetch_req_ready != data_req_ready)
        else fail_event("contention did not grant exactly one requester");
      if (have_grant) begin
        fetch_should_win = (last_grant_seen == PORT_DATA);
        assert (fetch_req_ready == fetch_should_win)
          else fail_value("round robin fetch grant", 64'(fetch_should_win),
                          64'(fetch_req_ready));
      end
    end else if (fetch_req_valid) begin
      assert (fetch_req_ready) else fail_event("lone fetch request was not granted");
    end else if (data_req_valid) begin
      assert (data_req_ready) else fail_event("lone load/store request was not granted");
    end
  endtask

  task automatic record_transfers();
    data_pend  = data_req_valid && data_req_ready;
    fetch_pend = fetch_req_valid && fetch_req_ready;
    if (data_pend) begin
      data_pend_idx = cur_idx;
      if (data_req_write) begin
        apply_store(data_req_addr, data_req_size, data_req_wdata);
      end
      last_grant_seen = PORT_DATA;
      have_grant      = 1'b1;
    end
    if (fetch_pend) begin
      predict_fetch(fetch_req_addr);
      last_grant_seen = PORT_FETCH;
      have_grant      = 1'b1;
    end
  endtask

  // outputs sampled mid cycle away from the driving edge
  always @(negedge clk) begin
    if (!arst_n) begin
      assert (!fetch_resp_valid && !data_resp_valid)
        else fail_event("response valid while in reset");
      assert (!fetch_req_ready && !data_req_ready) else fail_event("ready high while in reset");
    end else begin
      check_responses();
      check_grant();
      record_transfers();
    end
  end

  task automatic drive_patterns();
    for (int i = 0; i < NUM_PATTERNS; i++) begin
      @(posedge clk);
      data_req_valid <= 1'b1;
      data_req_write <= pat_mem[i*PAT_FIELDS][0];
      data_req_size  <= access_size_t'(pat_mem[i*PAT_FIELDS+1][1:0]);
      data_req_addr  <= pat_mem[i*PAT_FIELDS+2][ADDR_WIDTH-1:0];
      data_req_wdata <= pat_mem[i*PAT_FIELDS+3];
      cur_idx        <= i;
      // hold until the arbiter takes it
      do @(negedge clk); while (!data_req_ready);
    end
    @(posedge clk);
    data_req_valid <= 1'b0;
  endtask

  task automatic run_fetch_traffic();
    @(posedge clk);
    while (!data_done) begin
      rng_state = next_random(rng_state);
      // about three fetches in four cycles over words 0 to 7
      if (rng_state[1:0] != 2'b00) begin
        fetch_req_valid <= 1'b1;
        fetch_req_addr  <= ADDR_WIDTH'({rng_state[4:2], 3'b000});
        do @(negedge clk); while (!fetch_req_ready);
      end else begin
        fetch_req_valid <= 1'b0;
      end
      @(posedge clk);
    end
    fetch_req_valid <= 1'b0;
  endtask

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    fail_event("timeout, the run hung before all accesses completed");
  end

  initial begin
    arst_n          = 1'b0;
    fetch_req_valid = 1'b0;
    fetch_req_addr  = '0;
    data_req_valid  = 1'b0;
    data_req_write  = 1'b0;
    data_req_size   = SIZE_BYTE;
    data_req_addr   = '0;
    data_req_wdata  = '0;
    rng_state       = 32'd5;
    cur_idx         = 0;
    data_done       = 1'b0;
    data_pend       = 1'b0;
    data_pend_idx   = 0;
    fetch_pend      = 1'b0;
    fetch_exp       = '0;
    fetch_known     = '0;
    have_grant      = 1'b0;
    last_grant_seen = PORT_FETCH;
    fetch_resps     = 0;
    contended       = 0;
    for (int i = 0; i < MODEL_BYTES; i++) begin
      model_mem[i]   = 8'h00;
      model_known[i] = 1'b0;
    end
    $readmemh("bench/mem_patterns.hex", pat_mem);
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    // idle cycles where no response may show up
    repeat (3) @(posedge clk);
    fork
      begin
        drive_patterns();
        @(negedge clk);
        data_done = 1'b1;
      end
      run_fetch_traffic();
    join
    repeat (3) @(negedge clk);
    assert (fetch_resps > 0) else fail_event("no fetch request was ever accepted");
    assert (contended > 0) else fail_event("fetch and load/store requests never collided");
    $display("TEST OK");
    $finish;
  end

endmodule : tb_mem_subsystem

`default_nettype wire

// File: hw/lsu_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_align
  import mem_pkg::*, lsu_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  // data port request
  input  logic                  data_req_valid,
  output logic                  data_req_ready,
  input  logic                  data_req_write,
  input  access_size_t          data_req_size,
  input  logic [ADDR_WIDTH-1:0] data_req_addr,
  input  word_t                 data_req_wdata,
  // request towards the arbiter
  output logic                  mem_valid,
  input  logic                  mem_ready,
  output logic [ADDR_WIDTH-1:0] mem_addr,
  output logic                  mem_write,
  output byte_mask_t            mem_mask,
  output word_t                 mem_wdata,
  // response from the arbiter
  input  logic                  mem_resp_valid,
  input  word_t                 mem_resp_rdata,
  // data port response
  output logic                  data_resp_valid,
  output word_t                 data_resp_rdata,
  output logic                  data_resp_misaligned
);

  logic [OFFSET_BITS-1:0] req_off;
  logic [OFFSET_BITS-1:0] align_bits;
  logic                   req_misaligned;
  byte_mask_t             size_mask;

  // captured at the accepting edge for the response
  logic [OFFSET_BITS-1:0] off_q;
  access_size_t           size_q;
  logic                   misaligned_q;
  logic                   write_q;

  word_t                  rd_shifted;
  word_t                  keep_bits;
  byte_mask_t             keep_mask;

  assign req_off = data_req_addr[OFFSET_BITS-1:0];

  // offset bits that must be zero for this size
  assign align_bits = OFFSET_BITS'((32'd1 << data_req_size) - 32'd1);
  assign req_misaligned = (req_off & align_bits) != '0;

  // low lanes covered by the access, before shifting to the offset
  assign size_mask = byte_mask_t'((32'd1 << (32'd1 << data_req_size)) - 32'd1);

  // request side is pure combinational
  assign mem_valid      = data_req_valid;
  assign data_req_ready = mem_ready;
  assign mem_addr       = data_req_addr;
  assign mem_write      = data_req_write;
  assign mem_mask       = req_misaligned ? '0 : byte_mask_t'(size_mask << req_off);
  assign mem_wdata      = data_req_wdata << {req_off, 3'b000};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      off_q        <= '0;
      size_q       <= SIZE_BYTE;
      misaligned_q <= 1'b0;
      write_q      <= 1'b0;
    end else if (data_req_valid && mem_ready) begin
      off_q        <= req_off;
      size_q       <= data_req_size;
      misaligned_q <= req_misaligned;
      write_q      <= data_req_write;
    end
  end

  // bring the lane down to bit 0
  assign rd_shifted = mem_resp_rdata >> {off_q, 3'b000};
  assign keep_mask  = byte_mask_t'((32'd1 << (32'd1 << size_q)) - 32'd1);

  always_comb begin
    for (int b = 0; b < WORD_BYTES; b++) begin
      keep_bits[b*8 +: 8] = {8{keep_mask[b]}};
    end
  end

  // writes and rejected accesses return zero
  assign data_resp_valid      = mem_resp_valid;
  assign data_resp_rdata      = (write_q || misaligned_q) ? '0 : (rd_shifted & keep_bits);
  assign data_resp_misaligned = mem_resp_valid && misaligned_q;

  // an aligned store enables exactly its own byte count
  a_store_mask_width: assert property (
    @(posedge clk) disable iff (!arst_n)
    (mem_valid && mem_write && !req_misaligned)
      |-> ($countones(mem_mask) == (32'd1 << data_req_size))
  ) else $error("store mask does not match access size");

endmodule : lsu_align

`default_nettype wire

// File: hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    SIZE_BYTE   = 2'd0,
    SIZE_HALF   = 2'd1,
    SIZE_WORD   = 2'd2,
    SIZE_DOUBLE = 2'd3
  } access_size_t;

  // requesters sharing the ram port
  typedef enum logic {
    PORT_FETCH = 1'b0,
    PORT_DATA  = 1'b1
  } port_id_t;

endpackage : lsu_pkg

`default_nettype wire

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
  import mem_pkg::*, lsu_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
) (
  input  logic                              clk,
  input  logic                              arst_n,
  // fetch requester
  input  logic                              fetch_req_valid,
  output logic                              fetch_req_ready,
  input  logic [ADDR_WIDTH-1:0]             fetch_req_addr,
  output logic                              fetch_resp_valid,
  output word_t                             fetch_resp_data,
  // data requester, already lane aligned
  input  logic                              mem_valid,
  output logic                              mem_ready,
  input  logic [ADDR_WIDTH-1:0]             mem_addr,
  input  logic                              mem_write,
  input  byte_mask_t                        mem_mask,
  input  word_t                             mem_wdata,
  output logic                              mem_resp_valid,
  output word_t                             mem_resp_rdata,
  // ram port
  output logic                              ram_en,
  output logic                              ram_write,
  output logic [ADDR_WIDTH-OFFSET_BITS-1:0] ram_word_addr,
  output byte_mask_t                        ram_mask,
  output word_t                             ram_wdata,
  input  word_t                             ram_rdata
);

  // ready stays low until the first cycle after reset
  logic     running;
  port_id_t last_grant;
  logic     pend_valid;
  port_id_t pend_port;
  logic     fetch_fire;
  logic     data_fire;

  // a lone requester wins, otherwise the one not served last
  assign fetch_req_ready = running && (!mem_valid || last_grant == PORT_DATA);
  assign mem_ready       = running && (!fetch_req_valid || last_grant == PORT_FETCH);

  assign fetch_fire = fetch_req_valid && fetch_req_ready;
  assign data_fire  = mem_valid && mem_ready;

  always_comb begin
    ram_en    = fetch_fire || data_fire;
    ram_write = data_fire && mem_write;
    ram_wdata = mem_wdata;
    if (data_fire) begin
      ram_word_addr = mem_addr[ADDR_WIDTH-1:OFFSET_BITS];
      ram_mask      = mem_mask;
    end else begin
      ram_word_addr = fetch_req_addr[ADDR_WIDTH-1:OFFSET_BITS];
      // fetch never writes
      ram_mask      = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      running    <= 1'b0;
      last_grant <= PORT_DATA;
      pend_valid <= 1'b0;
      pend_port  <= PORT_FETCH;
    end else begin
      running    <= 1'b1;
      pend_valid <= ram_en;
      if (ram_en) begin
        last_grant <= data_fire ? PORT_DATA : PORT_FETCH;
        pend_port  <= data_fire ? PORT_DATA : PORT_FETCH;
      end
    end
  end

  // read data lands one cycle after the grant
  assign fetch_resp_valid = pend_valid && pend_port == PORT_FETCH;
  assign mem_resp_valid   = pend_valid && pend_port == PORT_DATA;
  assign fetch_resp_data  = ram_rdata;
  assign mem_resp_rdata   = ram_rdata;

  a_single_grant: assert property (
    @(posedge clk) disable iff (!arst_n)
    (fetch_req_valid && mem_valid) |-> !(fetch_req_ready && mem_ready)
  ) else $error("both requesters granted in one cycle");

  a_single_response: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(fetch_resp_valid && mem_resp_valid)
  ) else $error("two responses in one cycle");

endmodule : mem_arbiter

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // bytes per memory word
  localparam int WORD_BYTES = 8;

  localparam int WORD_BITS = WORD_BYTES * 8;

  // byte offset bits inside one word
  localparam int OFFSET_BITS = $clog2(WORD_BYTES);

  // one memory or data word
  typedef logic [WORD_BITS-1:0] word_t;

  // one enable per byte lane
  typedef logic [WORD_BYTES-1:0] byte_mask_t;

endpackage : mem_pkg

`default_nettype wire

// File: hw/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
  import mem_pkg::*, lsu_pkg::*;
#(
  parameter int DEPTH_WORDS = 256,
  parameter int ADDR_WIDTH  = 16
) (
  input  logic                  clk,
  input  logic                  arst_n,
  // instruction fetch port
  input  logic                  fetch_req_valid,
  output logic                  fetch_req_ready,
  input  logic [ADDR_WIDTH-1:0] fetch_req_addr,
  output logic                  fetch_resp_valid,
  output word_t                 fetch_resp_data,
  // load/store port
  input  logic                  data_req_valid,
  output logic                  data_req_ready,
  input  logic                  data_req_write,
  input  access_size_t          data_req_size,
  input  logic [ADDR_WIDTH-1:0] data_req_addr,
  input  word_t                 data_req_wdata,
  output logic                  data_resp_valid,
  output word_t                 data_resp_rdata,
  output logic                  data_resp_misaligned
);

  // aligned data request into the arbiter
  logic                              mem_valid;
  logic                              mem_ready;
  logic [ADDR_WIDTH-1:0]             mem_addr;
  logic                              mem_write;
  byte_mask_t                        mem_mask;
  word_t                             mem_wdata;
  logic                              mem_resp_valid;
  word_t                             mem_resp_rdata;

  // ram port
  logic                              ram_en;
  logic                              ram_write;
  logic [ADDR_WIDTH-OFFSET_BITS-1:0] ram_word_addr;
  byte_mask_t                        ram_mask;
  word_t                             ram_wdata;
  word_t                             ram_rdata;

  lsu_align #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_lsu_align (
    .clk                  (clk),
    .arst_n               (arst_n),
    .data_req_valid       (data_req_valid),
    .data_req_ready       (data_req_ready),
    .data_req_write       (data_req_write),
    .data_req_size        (data_req_size),
    .data_req_addr        (data_req_addr),
    .data_req_wdata       (data_req_wdata),
    .mem_valid            (mem_valid),
    .mem_ready            (mem_ready),
    .mem_addr             (mem_addr),
    .mem_write            (mem_write),
    .mem_mask             (mem_mask),
    .mem_wdata            (mem_wdata),
    .mem_resp_valid       (mem_resp_valid),
    .mem_resp_rdata       (mem_resp_rdata),
    .data_resp_valid      (data_resp_valid),
    .data_resp_rdata      (data_resp_rdata),
    .data_resp_misaligned (data_resp_misaligned)
  );

  mem_arbiter #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_mem_arbiter (
    .clk              (clk),
    .arst_n           (arst_n),
    .fetch_req_valid  (fetch_req_valid),
    .fetch_req_ready  (fetch_req_ready),
    .fetch_req_addr   (fetch_req_addr),
    .fetch_resp_valid (fetch_resp_valid),
    .fetch_resp_data  (fetch_resp_data),
    .mem_valid        (mem_valid),
    .mem_ready        (mem_ready),
    .mem_addr         (mem_addr),
    .mem_write        (mem_write),
    .mem_mask         (mem_mask),
    .mem_wdata        (mem_wdata),
    .mem_resp_valid   (mem_resp_valid),
    .mem_resp_rdata   (mem_resp_rdata),
    .ram_en           (ram_en),
    .ram_write        (ram_write),
    .ram_word_addr    (ram_word_addr),
    .ram_mask         (ram_mask),
    .ram_wdata        (ram_wdata),
    .ram_rdata        (ram_rdata)
  );

  sram_bank #(
    .DEPTH_WORDS (DEPTH_WORDS),
    .ADDR_WIDTH  (ADDR_WIDTH)
  ) u_sram_bank (
    .clk           (clk),
    .ram_en        (ram_en),
    .ram_write     (ram_write),
    .ram_word_addr (ram_word_addr),
    .ram_mask      (ram_mask),
    .ram_wdata     (ram_wdata),
    .ram_rdata     (ram_rdata)
  );

endmodule : mem_subsystem

`default_nettype wire

// File: hw/sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sram_bank
  import mem_pkg::*;
#(
  parameter int DEPTH_WORDS = 256,
  parameter int ADDR_WIDTH  = 16
) (
  input  logic                              clk,
  input  logic                              ram_en,
  input  logic                              ram_write,
  input  logic [ADDR_WIDTH-OFFSET_BITS-1:0] ram_word_addr,
  input  byte_mask_t                        ram_mask,
  input  word_t                             ram_wdata,
  output word_t                             ram_rdata
);

  localparam int INDEX_BITS = $clog2(DEPTH_WORDS);

  word_t                  mem_array [DEPTH_WORDS];
  logic [INDEX_BITS-1:0]  index;

  assign index = ram_word_addr[INDEX_BITS-1:0];

  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_write) begin
        // only enabled lanes change
        for (int b = 0; b < WORD_BYTES; b++) begin
          if (ram_mask[b]) begin
            mem_array[index][b*8 +: 8] <= ram_wdata[b*8 +: 8];
          end
        end
      end else begin
        ram_rdata <= mem_array[index];
      end
    end
  end

  // requesters must stay inside the bank
  a_addr_in_range: assert property (
    @(posedge clk)
    ram_en |-> (ram_word_addr < DEPTH_WORDS)
  ) else $error("ram word address %0d beyond depth", ram_word_addr);

endmodule : sram_bank

`default_nettype wire

// File: src.f
hw/mem_pkg.sv
hw/lsu_pkg.sv
hw/lsu_align.sv
hw/mem_arbiter.sv
hw/sram_bank.sv
hw/mem_subsystem.sv
bench/tb_mem_subsystem.sv
